/* build.f */
+incdir+.
video_pkg.sv
pattern_gen.sv
line_fifo.sv
frame_monitor.sv
reg_bank.sv
video_top.sv
tb_video_top.sv

/* frame_monitor.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module frame_monitor (
    input  logic                    clk_pixel,
    input  logic                    fifo_reset,
    input  logic                    in_valid_i,
    input  video_pkg::video_beat_t  in_beat_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output video_pkg::video_beat_t  out_beat_o,
    input  logic                    out_ready_i,
    output logic [15:0]             frame_count_o,       // finished frames
    output logic [`VID_BEATS_W-1:0] last_frame_beats_o,  // beats of last frame
    output logic                    frame_error_o        // sticky
);

    localparam logic [`VID_BEATS_W-1:0] full_frame =
        `VID_BEATS_W'(`VID_H_ACTIVE * `VID_V_ACTIVE);
    localparam logic [`VID_COORD_W-1:0] last_line = `VID_COORD_W'(`VID_V_ACTIVE - 1);

    logic [`VID_BEATS_W-1:0] beat_cnt_q;  // beats since last tuser
    logic [`VID_BEATS_W-1:0] beat_cnt_nx;
    logic                    take;
    logic                    frame_done;

    // ------------------------------
    // pass-through
    // ------------------------------
    assign out_valid_o = in_valid_i;
    assign out_beat_o  = in_beat_i;
    assign in_ready_o  = out_ready_i;  // combinational back to fifo pop

    assign take        = in_valid_i && out_ready_i;
    assign beat_cnt_nx = in_beat_i.tuser ? `VID_BEATS_W'(1) : beat_cnt_q + 1'b1;
    assign frame_done  = in_beat_i.tlast &&
        (in_beat_i.pixel[`VID_PIXEL_W-1 -: `VID_COORD_W] == last_line);  // last line

    // ------------------------------
    // counters
    // ------------------------------
    always_ff @(posedge clk_pixel) begin
        if (fifo_reset) begin
            beat_cnt_q         <= '0;
            frame_count_o      <= '0;
            last_frame_beats_o <= '0;
            frame_error_o      <= 1'b0;
        end else if (take) begin
            beat_cnt_q <= beat_cnt_nx;
            if (in_beat_i.tuser && (beat_cnt_q != '0) && (beat_cnt_q != full_frame)) begin
                frame_error_o <= 1'b1;  // short or long frame before this one
            end
            if (frame_done) begin
                frame_count_o      <= frame_count_o + 1'b1;
                last_frame_beats_o <= beat_cnt_nx;  // includes this beat
            end
        end
    end

    // stalled beat held steady by the fifo
    a_hold_when_stalled: assert property (@(posedge clk_pixel) disable iff (fifo_reset)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o)));

endmodule

/* line_fifo.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module line_fifo (
    input  logic                   clk_pixel,
    input  logic                   fifo_reset,
    input  logic                   push_i,   // write side
    input  video_pkg::video_beat_t beat_i,
    output logic                   afull_o,  // level at or above threshold
    output logic [4:0]             level_o,  // 0 .. depth
    output logic                   valid_o,  // read side
    output video_pkg::video_beat_t beat_o,
    input  logic                   ready_i
);

    localparam int ptr_w = $clog2(`VID_FIFO_DEPTH);

    video_pkg::video_beat_t mem [`VID_FIFO_DEPTH];  // circular buffer
    logic [ptr_w-1:0]       wr_ptr_q;
    logic [ptr_w-1:0]       rd_ptr_q;
    logic [4:0]             level_q;
    logic                   pop;

    assign valid_o = (level_q != '0);
    assign beat_o  = mem[rd_ptr_q];  // head of queue
    assign pop     = valid_o && ready_i;
    assign afull_o = (level_q >= 5'(`VID_FIFO_AFULL));
    assign level_o = level_q;

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk_pixel) begin
        if (push_i) begin
            mem[wr_ptr_q] <= beat_i;
        end
    end

    // ------------------------------
    // pointers and level
    // ------------------------------
    always_ff @(posedge clk_pixel) begin
        if (fifo_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;  // none or both
            endcase
        end
    end

    // generator stall margin must keep us below depth
    a_no_push_full: assert property (@(posedge clk_pixel) disable iff (fifo_reset)
        push_i |-> (level_q < 5'(`VID_FIFO_DEPTH)));

    // level tracks the pointer distance, modulo depth
    a_level_matches_ptrs: assert property (@(posedge clk_pixel) disable iff (fifo_reset)
        (wr_ptr_q - rd_ptr_q) == level_q[ptr_w-1:0]);

endmodule

/* pattern_gen.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module pattern_gen (
    input  logic                   clk_pixel,
    input  logic                   fifo_reset,
    input  logic                   enable_i,      // start permission, sampled in idle
    input  logic                   fifo_afull_i,  // stall from line fifo
    output video_pkg::video_beat_t beat_o,
    output logic                   push_o,        // beat_o valid this cycle
    output logic                   active_o       // frame in progress
);

    localparam logic [`VID_COORD_W-1:0] last_col  = `VID_COORD_W'(`VID_H_ACTIVE - 1);
    localparam logic [`VID_COORD_W-1:0] last_line = `VID_COORD_W'(`VID_V_ACTIVE - 1);

    video_pkg::pattern_state_e state_q;
    logic [`VID_COORD_W-1:0]   col_q;   // column of next beat
    logic [`VID_COORD_W-1:0]   line_q;  // line of next beat
    logic                      step;    // emit a beat at this edge

    assign step     = (state_q == video_pkg::PAT_LINE) && !fifo_afull_i;
    assign active_o = (state_q != video_pkg::PAT_IDLE);

    // ------------------------------
    // FSM and counters
    // ------------------------------
    always_ff @(posedge clk_pixel) begin
        if (fifo_reset) begin
            state_q <= video_pkg::PAT_IDLE;
            col_q   <= '0;
            line_q  <= '0;
            push_o  <= 1'b0;
        end else begin
            push_o <= step;  // one beat per unstalled cycle
            case (state_q)
                video_pkg::PAT_IDLE: begin
                    if (enable_i) begin
                        state_q <= video_pkg::PAT_LINE;  // new frame at (0,0)
                        col_q   <= '0;
                        line_q  <= '0;
                    end
                end
                video_pkg::PAT_LINE: begin
                    if (step) begin
                        if (col_q == last_col) begin
                            col_q   <= '0;
                            state_q <= video_pkg::PAT_LINE_END;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                video_pkg::PAT_LINE_END: begin
                    if (line_q == last_line) begin
                        line_q  <= '0;
                        state_q <= video_pkg::PAT_FRAME_END;
                    end else begin
                        line_q  <= line_q + 1'b1;
                        state_q <= video_pkg::PAT_LINE;
                    end
                end
                video_pkg::PAT_FRAME_END: begin
                    state_q <= video_pkg::PAT_IDLE;  // enable rechecked there
                end
                default: state_q <= video_pkg::PAT_IDLE;
            endcase
        end
    end

    // beat payload, built from the counters before they step
    always_ff @(posedge clk_pixel) begin
        if (step) begin
            beat_o.tuser <= (col_q == '0) && (line_q == '0);  // pixel (0,0)
            beat_o.tlast <= (col_q == last_col);               // end of line
            beat_o.pixel <= {line_q, col_q};
        end
    end

    // every line end leaves one empty cycle on the push side
    a_gap_after_line: assert property (@(posedge clk_pixel) disable iff (fifo_reset)
        (push_o && beat_o.tlast) |=> !push_o);

endmodule

/* reg_bank.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module reg_bank (
    input  logic                    clk_pixel,
    input  logic                    fifo_reset,
    input  logic                    host_req_i,   // four-phase request
    input  video_pkg::host_cmd_t    host_cmd_i,   // stable while req high
    output logic                    host_ack_o,
    output logic [`VID_REG_W-1:0]   host_rdata_o, // valid while ack high
    output logic                    enable_o,     // REG_CTRL bit 0
    input  logic                    active_i,
    input  logic [15:0]             frame_count_i,
    input  logic [`VID_BEATS_W-1:0] last_frame_beats_i,
    input  logic                    frame_error_i,
    input  logic [4:0]              fifo_level_i
);

    logic                  ack_q;
    logic                  enable_q;
    logic [`VID_REG_W-1:0] rdata_q;
    logic [`VID_REG_W-1:0] rd_mux;  // selected read value
    logic [`VID_REG_W-1:0] status;
    logic                  strobe;  // first edge of a request

    assign strobe       = host_req_i && !ack_q;
    assign host_ack_o   = ack_q;
    assign host_rdata_o = rdata_q;
    assign enable_o     = enable_q;

    // ------------------------------
    // read-back
    // ------------------------------
    always_comb begin
        status     = '0;
        status[0]  = frame_error_i;
        status[8:4] = fifo_level_i;
        status[12] = active_i;  // generator mid-frame
    end

    always_comb begin
        case (host_cmd_i.addr)
            video_pkg::REG_CTRL:        rd_mux = `VID_REG_W'(enable_q);
            video_pkg::REG_FRAME_COUNT: rd_mux = `VID_REG_W'(frame_count_i);
            video_pkg::REG_FRAME_BEATS: rd_mux = `VID_REG_W'(last_frame_beats_i);
            video_pkg::REG_STATUS:      rd_mux = status;
            default:                    rd_mux = '0;
        endcase
    end

    // ------------------------------
    // handshake and control
    // ------------------------------
    always_ff @(posedge clk_pixel) begin
        if (fifo_reset) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            ack_q <= host_req_i;  // rises and falls one edge after req
            if (strobe && host_cmd_i.write && (host_cmd_i.addr == video_pkg::REG_CTRL)) begin
                enable_q <= host_cmd_i.wdata[0];  // ro targets ignored
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (strobe && !host_cmd_i.write) begin
            rdata_q <= rd_mux;  // held for the ack phase
        end
    end

    // host keeps the command steady for the whole request
    a_cmd_stable: assert property (@(posedge clk_pixel) disable iff (fifo_reset)
        (host_req_i && $past(host_req_i)) |-> $stable(host_cmd_i));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the video testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_video_top \
        -f build.f -o tb_video_top; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_video_top > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "^Result: PASSED$" "$log"; then
    exit 1
fi
exit 0

/* tb_video_top.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module tb_video_top;

    localparam int frame_beats   = `VID_H_ACTIVE * `VID_V_ACTIVE;
    localparam int host_timeout  = 20;      // cycles for ack to move
    localparam int frame_timeout = 700000;  // cycles per frame at 75% ready
    localparam int idle_cycles   = 2000;

    logic                          clk_pixel  = 1'b0;
    logic                          fifo_reset = 1'b1;
    logic                          host_req_i = 1'b0;
    video_pkg::host_cmd_t          host_cmd_i = '0;
    logic                          ready_i    = 1'b0;
    logic                          host_ack_o;
    logic [`VID_REG_W-1:0]         host_rdata_o;
    video_pkg::video_beat_t        out_beat_o;
    logic                          out_valid_o;

    // reference model state, updated at the falling edge
    int                            exp_col     = 0;
    int                            exp_line    = 0;
    int                            beats_taken = 0;
    video_pkg::video_beat_t        expect_beat;
    video_pkg::video_beat_t        last_beat;
    string                         current_test = "reset";
    logic [`VID_REG_W-1:0]         rdata;

    video_top i_video_top (
        .clk_pixel    (clk_pixel),
        .fifo_reset   (fifo_reset),
        .host_req_i   (host_req_i),
        .host_cmd_i   (host_cmd_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .out_beat_o   (out_beat_o),
        .out_valid_o  (out_valid_o),
        .ready_i      (ready_i)
    );

    always #50 clk_pixel = ~clk_pixel;  // 100 ns period

    // sink back-pressure, ready about 3 cycles in 4
    initial begin
        void'($urandom(32'he778_5921));  // one seed for the whole run
        forever begin
            @(posedge clk_pixel);
            ready_i <= (($urandom % 4) != 0);
        end
    end

    // ------------------------------
    // failure reporting
    // ------------------------------
    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR in %s: %s", current_test, msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("MISMATCH test=%s check=%s expected=0x%08h actual=0x%08h",
                 current_test, what, exp_v, act_v);
        stop_run();
    endtask

    task automatic compare_word(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        assert (exp_v == act_v) else report_mismatch(what, exp_v, act_v);
    endtask

    // beat predicted from the counting pattern
    function automatic video_pkg::video_beat_t build_beat(input int col, input int line);
        video_pkg::video_beat_t b;
        b.tuser = (col == 0) && (line == 0);   // frame start
        b.tlast = (col == `VID_H_ACTIVE - 1);  // line end
        b.pixel = {`VID_COORD_W'(line), `VID_COORD_W'(col)};
        return b;
    endfunction

    // ------------------------------
    // stream monitor and model
    // ------------------------------
    always @(negedge clk_pixel) begin
        if (!fifo_reset && out_valid_o && ready_i) begin  // taken at next edge
            expect_beat = build_beat(exp_col, exp_line);
            assert (out_beat_o == expect_beat)
                else report_mismatch("beat", 32'(expect_beat), 32'(out_beat_o));
            last_beat   = out_beat_o;
            beats_taken = beats_taken + 1;
            exp_col     = exp_col + 1;
            if (exp_col == `VID_H_ACTIVE) begin
                exp_col  = 0;
                exp_line = exp_line + 1;
                if (exp_line == `VID_V_ACTIVE) begin
                    exp_line = 0;  // next frame
                end
            end
        end
    end

    // ------------------------------
    // host port, four-phase
    // ------------------------------
    task automatic host_access(input logic wr, input video_pkg::reg_addr_e addr,
                               input logic [`VID_REG_W-1:0] wdata,
                               output logic [`VID_REG_W-1:0] data);
        video_pkg::host_cmd_t cmd;
        int                   cycles;
        cmd.write = wr;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        @(negedge clk_pixel);
        assert (host_ack_o == 1'b0) else report_failure("ack was high before req rose");
        @(posedge clk_pixel);
        host_cmd_i <= cmd;
        host_req_i <= 1'b1;
        cycles = 0;
        @(negedge clk_pixel);
        while (host_ack_o !== 1'b1) begin  // phase 2
            assert (cycles < host_timeout) else report_failure("ack never rose");
            cycles = cycles + 1;
            @(negedge clk_pixel);
        end
        data = host_rdata_o;  // valid while ack high
        @(posedge clk_pixel);
        host_req_i <= 1'b0;
        cycles = 0;
        @(negedge clk_pixel);
        while (host_ack_o !== 1'b0) begin  // phase 4
            assert (cycles < host_timeout) else report_failure("ack never fell after req dropped");
            cycles = cycles + 1;
            @(negedge clk_pixel);
        end
    endtask

    task automatic write_reg(input video_pkg::reg_addr_e addr, input logic [31:0] wdata);
        logic [`VID_REG_W-1:0] unused;
        host_access(1'b1, addr, wdata, unused);
    endtask

    task automatic read_reg(input video_pkg::reg_addr_e addr,
                            output logic [`VID_REG_W-1:0] data);
        host_access(1'b0, addr, '0, data);
    endtask

    // model counters are stable at the rising edge
    task automatic wait_beats(input int target, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk_pixel);
        while (beats_taken < target) begin
            assert (cycles < limit) else report_failure("timed out waiting for stream beats");
            cycles = cycles + 1;
            @(posedge clk_pixel);
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        repeat (5) @(posedge clk_pixel);
        fifo_reset <= 1'b0;

        current_test = "reset";
        repeat (20) begin
            @(negedge clk_pixel);
            assert (out_valid_o == 1'b0) else report_failure("out_valid_o rose without enable");
        end
        for (int a = 0; a < 4; a++) begin
            read_reg(video_pkg::reg_addr_e'(a), rdata);
            compare_word("register after reset", '0, rdata);
        end

        current_test = "pattern";
        write_reg(video_pkg::REG_CTRL, 32'd1);
        wait_beats(3 * frame_beats, 3 * frame_timeout);  // model checks each beat

        current_test = "counters";
        read_reg(video_pkg::REG_FRAME_COUNT, rdata);
        assert (rdata >= 32'd3) else report_mismatch("frame count at least", 32'd3, rdata);
        read_reg(video_pkg::REG_FRAME_BEATS, rdata);
        compare_word("frame beats", 32'(frame_beats), rdata);
        read_reg(video_pkg::REG_STATUS, rdata);
        compare_word("frame_error bit", '0, 32'(rdata[0]));

        current_test = "disable";
        wait_beats(3 * frame_beats + 100 * `VID_H_ACTIVE, frame_timeout);  // mid-frame
        write_reg(video_pkg::REG_CTRL, 32'd0);
        wait_beats(4 * frame_beats, frame_timeout);  // frame runs to its end
        compare_word("last beat", 32'(build_beat(`VID_H_ACTIVE - 1, `VID_V_ACTIVE - 1)),
                     32'(last_beat));
        repeat (idle_cycles) begin
            @(negedge clk_pixel);
            assert (out_valid_o == 1'b0) else report_failure("beat appeared after disable");
        end
        read_reg(video_pkg::REG_STATUS, rdata);
        compare_word("active bit", '0, 32'(rdata[12]));

        current_test = "restart";
        write_reg(video_pkg::REG_CTRL, 32'd1);
        wait_beats(4 * frame_beats + 1, frame_timeout);
        compare_word("first beat", 32'(build_beat(0, 0)), 32'(last_beat));
        wait_beats(4 * frame_beats + 10 * `VID_H_ACTIVE, frame_timeout);
        read_reg(video_pkg::REG_STATUS, rdata);
        compare_word("frame_error bit", '0, 32'(rdata[0]));

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* video_macros.svh */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ------------------------------
// frame geometry
// ------------------------------
`define VID_H_ACTIVE    640     // pixels per line
`define VID_V_ACTIVE    480     // lines per frame

`define VID_COORD_W     12      // one coordinate field
`define VID_PIXEL_W     24      // {line, column}

// ------------------------------
// buffering and host side
// ------------------------------
`define VID_FIFO_DEPTH  16      // line fifo entries
`define VID_FIFO_AFULL  12      // stall level for the generator
`define VID_REG_W       32      // host data width
`define VID_BEATS_W     20      // beat counter width, holds 640*480

`endif

/* video_pkg.sv */
`include "video_macros.svh"

package video_pkg;

    // ------------------------------
    // stream beat
    // ------------------------------
    typedef struct packed {
        logic                    tuser;  // first pixel of frame
        logic                    tlast;  // last pixel of line
        logic [`VID_PIXEL_W-1:0] pixel;  // line in upper half, column in lower
    } video_beat_t;

    // pattern generator FSM
    typedef enum logic [1:0] {
        PAT_IDLE      = 2'd0,  // waiting for enable
        PAT_LINE      = 2'd1,  // emitting pixels of a line
        PAT_LINE_END  = 2'd2,  // one gap cycle per line
        PAT_FRAME_END = 2'd3   // one gap cycle per frame
    } pattern_state_e;

    // ------------------------------
    // host port
    // ------------------------------
    typedef enum logic [1:0] {
        REG_CTRL        = 2'd0,  // r/w, bit 0 enable
        REG_FRAME_COUNT = 2'd1,  // ro
        REG_FRAME_BEATS = 2'd2,  // ro
        REG_STATUS      = 2'd3   // ro
    } reg_addr_e;

    typedef struct packed {
        logic                  write;  // 1 write, 0 read
        reg_addr_e             addr;
        logic [`VID_REG_W-1:0] wdata;
    } host_cmd_t;

endpackage

/* video_top.sv */
`timescale 1ns/1ps
`include "video_macros.svh"

module video_top (
    input  logic                   clk_pixel,
    input  logic                   fifo_reset,
    input  logic                   host_req_i,
    input  video_pkg::host_cmd_t   host_cmd_i,
    output logic                   host_ack_o,
    output logic [`VID_REG_W-1:0]  host_rdata_o,
    output video_pkg::video_beat_t out_beat_o,   // pixel stream
    output logic                   out_valid_o,
    input  logic                   ready_i
);

    // ------------------------------
    // internal nets
    // ------------------------------
    logic                    pattern_enable;
    logic                    pattern_active;
    video_pkg::video_beat_t  pat_beat;      // generator to fifo
    logic                    pat_push;
    logic                    fifo_afull;
    logic [4:0]              fifo_level;
    video_pkg::video_beat_t  fifo_beat;     // fifo to monitor
    logic                    fifo_valid;
    logic                    fifo_ready;
    logic [15:0]             frame_count;
    logic [`VID_BEATS_W-1:0] last_frame_beats;
    logic                    frame_error;

    pattern_gen i_pattern_gen (
        .clk_pixel    (clk_pixel),
        .fifo_reset   (fifo_reset),
        .enable_i     (pattern_enable),
        .fifo_afull_i (fifo_afull),
        .beat_o       (pat_beat),
        .push_o       (pat_push),
        .active_o     (pattern_active)
    );

    line_fifo i_line_fifo (
        .clk_pixel  (clk_pixel),
        .fifo_reset (fifo_reset),
        .push_i     (pat_push),
        .beat_i     (pat_beat),
        .afull_o    (fifo_afull),
        .level_o    (fifo_level),
        .valid_o    (fifo_valid),
        .beat_o     (fifo_beat),
        .ready_i    (fifo_ready)
    );

    frame_monitor i_frame_monitor (
        .clk_pixel          (clk_pixel),
        .fifo_reset         (fifo_reset),
        .in_valid_i         (fifo_valid),
        .in_beat_i          (fifo_beat),
        .in_ready_o         (fifo_ready),
        .out_valid_o        (out_valid_o),
        .out_beat_o         (out_beat_o),
        .out_ready_i        (ready_i),
        .frame_count_o      (frame_count),
        .last_frame_beats_o (last_frame_beats),
        .frame_error_o      (frame_error)
    );

    reg_bank i_reg_bank (
        .clk_pixel          (clk_pixel),
        .fifo_reset         (fifo_reset),
        .host_req_i         (host_req_i),
        .host_cmd_i         (host_cmd_i),
        .host_ack_o         (host_ack_o),
        .host_rdata_o       (host_rdata_o),
        .enable_o           (pattern_enable),
        .active_i           (pattern_active),
        .frame_count_i      (frame_count),
        .last_frame_beats_i (last_frame_beats),
        .frame_error_i      (frame_error),
        .fifo_level_i       (fifo_level)
    );

endmodule
